// File: async_fifo_pkg.sv
package async_fifo_pkg;

   localparam int DATA_W      = 32;           // fifo word width
   localparam int ADDR_W      = 4;            // ram address bits
   localparam int DEPTH       = 1 << ADDR_W;  // ram entries
   localparam int AXIL_ADDR_W = 8;            // csr byte address space
   localparam int STRB_W      = DATA_W / 8;   // one strobe per byte

   typedef logic [ADDR_W:0]        ptr_t;        // extra msb for wrap
   typedef logic [ADDR_W+1:0]      level_t;      // 0 .. DEPTH+1, head included
   typedef logic [DATA_W-1:0]      word_t;
   typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
   typedef logic [1:0]             resp_t;

   localparam axil_addr_t REG_DATA   = 8'h0;  // pop on read
   localparam axil_addr_t REG_STATUS = 8'h4;  // level, empty, underflow
   localparam axil_addr_t REG_CTRL   = 8'h8;  // threshold, irq enable

   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_SLVERR = 2'b10;

   typedef struct packed {
      logic   irq_en;     // bit 6
      level_t threshold;  // bits 5:0
   } ctrl_t;

   typedef struct packed {
      logic   underflow;  // bit 7, write 1 to clear
      logic   empty;      // bit 6
      level_t level;      // bits 5:0
   } status_t;

   typedef struct packed {
      logic               awvalid;
      axil_addr_t         awaddr;
      logic               wvalid;
      word_t              wdata;
      logic [STRB_W-1:0]  wstrb;
      logic               bready;
      logic               arvalid;
      axil_addr_t         araddr;
      logic               rready;
   } axil_req_t;

   typedef struct packed {
      logic  awready;
      logic  wready;
      logic  bvalid;
      resp_t bresp;
      logic  arready;
      logic  rvalid;
      word_t rdata;
      resp_t rresp;
   } axil_rsp_t;

   function automatic ptr_t bin2gray(input ptr_t b);
      return b ^ (b >> 1);
   endfunction

   function automatic ptr_t gray2bin(input ptr_t g);
      ptr_t b;
      b[ADDR_W] = g[ADDR_W];  // msb passes through
      for (int i = ADDR_W - 1; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

endpackage

// File: dual_clock_ram.sv
module dual_clock_ram (
   input  logic                                wclk,
   input  logic                                we,
   input  logic [async_fifo_pkg::ADDR_W-1:0]   waddr,
   input  async_fifo_pkg::word_t               wdata,
   input  logic                                rclk,
   input  logic [async_fifo_pkg::ADDR_W-1:0]   raddr,
   output async_fifo_pkg::word_t               rdata
);

   async_fifo_pkg::word_t mem [async_fifo_pkg::DEPTH];  // block ram array

   // producer side
   always_ff @(posedge wclk) begin
      if (we) begin
         mem[waddr] <= wdata;  // store word
      end
   end

   // consumer side, data one rclk later
   always_ff @(posedge rclk) begin
      rdata <= mem[raddr];  // registered read
   end

endmodule

// File: gray_sync.sv
module gray_sync (
   input  logic                  clk,
   input  logic                  rst_n,
   input  async_fifo_pkg::ptr_t  gray_in,
   output async_fifo_pkg::ptr_t  gray_out
);

   async_fifo_pkg::ptr_t meta;   // first stage, may go metastable
   async_fifo_pkg::ptr_t stable; // second stage

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         meta   <= '0;
         stable <= '0;
      end else begin
         meta   <= gray_in;  // async capture
         stable <= meta;     // resolve
      end
   end

   assign gray_out = stable;  // two cycles behind source

   // source pointer must move at most one gray step per destination sample,
   // otherwise a multi-bit change can be captured half old, half new
   property p_one_bit_step;
      @(posedge clk) disable iff (!rst_n)
         $countones(gray_in ^ $past(gray_in)) <= 1;
   endproperty

   a_one_bit_step: assert property (p_one_bit_step)
      else $error("gray_sync: source pointer moved more than one bit");

endmodule

// File: fifo_write_ctrl.sv
module fifo_write_ctrl (
   input  logic                                wclk,
   input  logic                                rst_n,      // rclk domain
   input  logic                                in_valid,
   input  async_fifo_pkg::word_t               in_data,
   output logic                                in_ready,
   input  async_fifo_pkg::ptr_t                rptr_gray,  // already in wclk
   output async_fifo_pkg::ptr_t                wptr_gray,
   output logic                                we,
   output logic [async_fifo_pkg::ADDR_W-1:0]   waddr,
   output async_fifo_pkg::word_t               wdata
);

   localparam int AW = async_fifo_pkg::ADDR_W;

   logic                 rst_meta;   // reset sync stage 1
   logic                 wrst_n;     // reset in wclk
   async_fifo_pkg::ptr_t wbin;       // binary write pointer
   async_fifo_pkg::ptr_t wgray;      // published gray pointer
   async_fifo_pkg::ptr_t wbin_next;
   async_fifo_pkg::ptr_t wgray_next;
   async_fifo_pkg::ptr_t rptr_wrap;  // read ptr one lap behind
   logic                 push;
   logic                 full;
   logic                 full_next;

   // bring reset into wclk
   always_ff @(posedge wclk) begin
      rst_meta <= rst_n;
      wrst_n   <= rst_meta;
   end

   assign push       = in_valid && in_ready;  // stream handshake
   assign wbin_next  = wbin + async_fifo_pkg::ptr_t'(push);
   assign wgray_next = async_fifo_pkg::bin2gray(wbin_next);

   // full when write is a full lap ahead, top two gray bits inverted
   assign rptr_wrap = {~rptr_gray[AW:AW-1], rptr_gray[AW-2:0]};
   assign full      = (wgray == rptr_wrap);
   assign full_next = (wgray_next == rptr_wrap);

   always_ff @(posedge wclk) begin
      if (!wrst_n) begin
         wbin     <= '0;
         wgray    <= '0;
         in_ready <= 1'b0;  // held off during reset
      end else begin
         wbin     <= wbin_next;
         wgray    <= wgray_next;  // registered, glitch free for the crossing
         in_ready <= !full_next;  // stale rptr only makes this pessimistic
      end
   end

   assign we        = push;
   assign waddr     = wbin[AW-1:0];
   assign wdata     = in_data;
   assign wptr_gray = wgray;

   // no ram write may land on an entry the reader still owns
   property p_no_write_full;
      @(posedge wclk) disable iff (!wrst_n)
         !(we && full);
   endproperty

   a_no_write_full: assert property (p_no_write_full)
      else $error("fifo_write_ctrl: write while full");

endmodule

// File: fifo_read_ctrl.sv
module fifo_read_ctrl (
   input  logic                                rclk,
   input  logic                                rst_n,
   input  async_fifo_pkg::ptr_t                wptr_gray,  // already in rclk
   output async_fifo_pkg::ptr_t                rptr_gray,
   output logic [async_fifo_pkg::ADDR_W-1:0]   raddr,
   input  async_fifo_pkg::word_t               rdata,
   input  logic                                pop,
   output logic                                head_valid,
   output async_fifo_pkg::word_t               head_data,
   output async_fifo_pkg::level_t              level
);

   async_fifo_pkg::ptr_t rbin;       // binary read pointer
   async_fifo_pkg::ptr_t rgray;      // published gray pointer
   async_fifo_pkg::ptr_t rbin_next;
   async_fifo_pkg::ptr_t wbin_sync;  // write pointer in binary
   async_fifo_pkg::ptr_t occ;        // words left in ram
   logic                 rd_pending; // ram read in flight
   logic                 ram_empty;
   logic                 slot_free;
   logic                 refill;

   assign wbin_sync = async_fifo_pkg::gray2bin(wptr_gray);
   assign ram_empty = (rgray == wptr_gray);  // gray compare, no conversion needed

   // head will be free next cycle: idle and nothing coming, or being popped
   assign slot_free = (!head_valid && !rd_pending) || pop;
   assign refill    = slot_free && !ram_empty;
   assign rbin_next = rbin + 1'b1;
   assign raddr     = rbin[async_fifo_pkg::ADDR_W-1:0];  // ram registers it

   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         rbin       <= '0;
         rgray      <= '0;
         rd_pending <= 1'b0;
         head_valid <= 1'b0;
      end else begin
         rd_pending <= refill;
         if (refill) begin
            rbin  <= rbin_next;
            rgray <= async_fifo_pkg::bin2gray(rbin_next);
         end
         if (rd_pending) begin
            head_valid <= 1'b1;  // ram data lands
         end else if (pop) begin
            head_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge rclk) begin
      if (rd_pending) begin
         head_data <= rdata;  // show-ahead word
      end
   end

   assign rptr_gray = rgray;
   assign occ       = wbin_sync - rbin;  // modulo pointer width
   // in-flight word already left the ram count, so it counts as head
   assign level     = async_fifo_pkg::level_t'(occ)
                    + async_fifo_pkg::level_t'(head_valid || rd_pending);

   // csr must only pop a word that is actually there
   property p_pop_needs_head;
      @(posedge rclk) disable iff (!rst_n)
         pop |-> head_valid;
   endproperty

   a_pop_needs_head: assert property (p_pop_needs_head)
      else $error("fifo_read_ctrl: pop without head word");

   // ram plus head, anything above means pointers out of step
   property p_level_bound;
      @(posedge rclk) disable iff (!rst_n)
         level <= async_fifo_pkg::level_t'(async_fifo_pkg::DEPTH + 1);
   endproperty

   a_level_bound: assert property (p_level_bound)
      else $error("fifo_read_ctrl: level %0d above capacity", level);

endmodule

// File: fifo_csr_axil.sv
module fifo_csr_axil (
   input  logic                        rclk,
   input  logic                        rst_n,
   input  async_fifo_pkg::axil_req_t   axil_req,
   output async_fifo_pkg::axil_rsp_t   axil_rsp,
   input  logic                        head_valid,
   input  async_fifo_pkg::word_t       head_data,
   input  async_fifo_pkg::level_t      level,
   output logic                        pop,
   output logic                        irq
);

   async_fifo_pkg::ctrl_t   ctrl_q;
   async_fifo_pkg::status_t status_img;  // status read view
   async_fifo_pkg::status_t wr_status;   // status write view
   async_fifo_pkg::resp_t   bresp_q;
   async_fifo_pkg::resp_t   rresp_q;
   async_fifo_pkg::resp_t   wr_resp;
   async_fifo_pkg::resp_t   rd_resp;
   async_fifo_pkg::word_t   rdata_q;
   async_fifo_pkg::word_t   rd_word;
   logic                    bvalid_q;
   logic                    rvalid_q;
   logic                    underflow_q;  // sticky
   logic                    wr_hs;
   logic                    ar_hs;
   logic                    ctrl_wr;
   logic                    uf_clr;
   logic                    uf_set;

   // aw and w taken together, none while b response held
   assign wr_hs = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
   assign ar_hs = axil_req.arvalid && !rvalid_q;  // one read outstanding

   assign status_img = '{underflow: underflow_q, empty: (level == '0), level: level};
   assign wr_status  = async_fifo_pkg::status_t'(
                          axil_req.wdata[$bits(async_fifo_pkg::status_t)-1:0]);

   // write decode
   always_comb begin
      wr_resp = async_fifo_pkg::RESP_OKAY;
      ctrl_wr = 1'b0;
      uf_clr  = 1'b0;
      case (axil_req.awaddr)
         async_fifo_pkg::REG_DATA:   wr_resp = async_fifo_pkg::RESP_OKAY;  // dropped
         async_fifo_pkg::REG_STATUS: uf_clr  = wr_hs && axil_req.wstrb[0]
                                             && wr_status.underflow;  // w1c
         async_fifo_pkg::REG_CTRL:   ctrl_wr = wr_hs && axil_req.wstrb[0];
         default:                    wr_resp = async_fifo_pkg::RESP_SLVERR;
      endcase
   end

   // read decode, data read doubles as pop
   always_comb begin
      rd_word = '0;
      rd_resp = async_fifo_pkg::RESP_OKAY;
      pop     = 1'b0;
      uf_set  = 1'b0;
      case (axil_req.araddr)
         async_fifo_pkg::REG_DATA: begin
            if (head_valid) begin
               rd_word = head_data;
               pop     = ar_hs;  // one pulse per accepted read
            end else begin
               rd_resp = async_fifo_pkg::RESP_SLVERR;  // nothing to give
               uf_set  = ar_hs;
            end
         end
         async_fifo_pkg::REG_STATUS: rd_word = async_fifo_pkg::word_t'(status_img);
         async_fifo_pkg::REG_CTRL:   rd_word = async_fifo_pkg::word_t'(ctrl_q);
         default:                    rd_resp = async_fifo_pkg::RESP_SLVERR;
      endcase
   end

   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         bvalid_q    <= 1'b0;
         bresp_q     <= async_fifo_pkg::RESP_OKAY;
         rvalid_q    <= 1'b0;
         rresp_q     <= async_fifo_pkg::RESP_OKAY;
         ctrl_q      <= '0;
         underflow_q <= 1'b0;
         irq         <= 1'b0;
      end else begin
         irq <= ctrl_q.irq_en && (level >= ctrl_q.threshold);  // one cycle behind level
         if (wr_hs) begin
            bvalid_q <= 1'b1;
            bresp_q  <= wr_resp;
         end else if (axil_req.bready) begin
            bvalid_q <= 1'b0;
         end
         if (ctrl_wr) begin
            ctrl_q <= async_fifo_pkg::ctrl_t'(
                         axil_req.wdata[$bits(async_fifo_pkg::ctrl_t)-1:0]);
         end
         if (ar_hs) begin
            rvalid_q <= 1'b1;
            rresp_q  <= rd_resp;
         end else if (axil_req.rready) begin
            rvalid_q <= 1'b0;
         end
         if (uf_clr) begin
            underflow_q <= 1'b0;
         end
         if (uf_set) begin
            underflow_q <= 1'b1;  // new underflow beats a clear
         end
      end
   end

   always_ff @(posedge rclk) begin
      if (ar_hs) begin
         rdata_q <= rd_word;  // held until rready
      end
   end

   assign axil_rsp = '{awready: wr_hs, wready: wr_hs,
                       bvalid:  bvalid_q, bresp: bresp_q,
                       arready: !rvalid_q,
                       rvalid:  rvalid_q, rdata: rdata_q, rresp: rresp_q};

   // a popped word is gone, so it must survive read back-pressure intact
   property p_r_stable;
      @(posedge rclk) disable iff (!rst_n)
         (rvalid_q && !axil_req.rready) |=> (rvalid_q && $stable(rdata_q));
   endproperty

   a_r_stable: assert property (p_r_stable)
      else $error("fifo_csr_axil: read response changed under back-pressure");

endmodule

// File: async_fifo_top.sv
module async_fifo_top (
   input  logic                        rclk,
   input  logic                        wclk,
   input  logic                        rst_n,
   input  logic                        in_valid,
   input  async_fifo_pkg::word_t       in_data,
   output logic                        in_ready,
   input  async_fifo_pkg::axil_req_t   axil_req,
   output async_fifo_pkg::axil_rsp_t   axil_rsp,
   output logic                        irq
);

   async_fifo_pkg::ptr_t              wptr_gray;       // wclk
   async_fifo_pkg::ptr_t              wptr_gray_rclk;  // after sync
   async_fifo_pkg::ptr_t              rptr_gray;       // rclk
   async_fifo_pkg::ptr_t              rptr_gray_wclk;  // after sync
   logic                              we;
   logic [async_fifo_pkg::ADDR_W-1:0] waddr;
   logic [async_fifo_pkg::ADDR_W-1:0] raddr;
   async_fifo_pkg::word_t             wdata;
   async_fifo_pkg::word_t             ram_rdata;
   async_fifo_pkg::word_t             head_data;
   async_fifo_pkg::level_t            level;
   logic                              head_valid;
   logic                              pop;

   fifo_write_ctrl wr_ctrl_i (
      .wclk      (wclk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_data   (in_data),
      .in_ready  (in_ready),
      .rptr_gray (rptr_gray_wclk),
      .wptr_gray (wptr_gray),
      .we        (we),
      .waddr     (waddr),
      .wdata     (wdata)
   );

   dual_clock_ram ram_i (
      .wclk  (wclk),
      .we    (we),
      .waddr (waddr),
      .wdata (wdata),
      .rclk  (rclk),
      .raddr (raddr),
      .rdata (ram_rdata)
   );

   // write pointer into read domain
   gray_sync wptr_sync_i (
      .clk      (rclk),
      .rst_n    (rst_n),
      .gray_in  (wptr_gray),
      .gray_out (wptr_gray_rclk)
   );

   // read pointer into write domain, long reset pulse covers the crossing
   gray_sync rptr_sync_i (
      .clk      (wclk),
      .rst_n    (rst_n),
      .gray_in  (rptr_gray),
      .gray_out (rptr_gray_wclk)
   );

   fifo_read_ctrl rd_ctrl_i (
      .rclk       (rclk),
      .rst_n      (rst_n),
      .wptr_gray  (wptr_gray_rclk),
      .rptr_gray  (rptr_gray),
      .raddr      (raddr),
      .rdata      (ram_rdata),
      .pop        (pop),
      .head_valid (head_valid),
      .head_data  (head_data),
      .level      (level)
   );

   fifo_csr_axil csr_i (
      .rclk       (rclk),
      .rst_n      (rst_n),
      .axil_req   (axil_req),
      .axil_rsp   (axil_rsp),
      .head_valid (head_valid),
      .head_data  (head_data),
      .level      (level),
      .pop        (pop),
      .irq        (irq)
   );

endmodule

// File: tb_async_fifo.sv
module tb_async_fifo;

   timeunit 1ns;
   timeprecision 100ps;

   localparam real RCLK_PERIOD     = 8.0;
   localparam real WCLK_PERIOD     = 11.0;    // unrelated to rclk on purpose
   localparam int  NUM_TESTS       = 6;
   localparam int  TEST_CYCLES     = 400;     // rclk cycles per test, rough
   localparam int  WATCHDOG_CYCLES = 2 * NUM_TESTS * TEST_CYCLES + 100;
   localparam int  CAPACITY        = async_fifo_pkg::DEPTH + 1;  // ram plus head

   logic                      rclk;
   logic                      wclk;
   logic                      rst_n;
   logic                      in_valid;
   async_fifo_pkg::word_t     in_data;
   logic                      in_ready;
   async_fifo_pkg::axil_req_t axil_req;
   async_fifo_pkg::axil_rsp_t axil_rsp;
   logic                      irq;

   async_fifo_pkg::word_t     sb[$];      // accepted words, push order
   int                        err_count;
   int                        check_count;
   int                        test_count;

   async_fifo_top dut_i (
      .rclk     (rclk),
      .wclk     (wclk),
      .rst_n    (rst_n),
      .in_valid (in_valid),
      .in_data  (in_data),
      .in_ready (in_ready),
      .axil_req (axil_req),
      .axil_rsp (axil_rsp),
      .irq      (irq)
   );

   always #(RCLK_PERIOD / 2.0) rclk = ~rclk;
   always #(WCLK_PERIOD / 2.0) wclk = ~wclk;

   task automatic check_word(input string name, input async_fifo_pkg::word_t got,
                             input async_fifo_pkg::word_t exp);
      check_count++;
      if (got !== exp) begin
         err_count++;
         $display("ERROR %0t %s: got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_resp(input string name, input async_fifo_pkg::resp_t got,
                             input async_fifo_pkg::resp_t exp);
      check_count++;
      if (got !== exp) begin
         err_count++;
         $display("ERROR %0t %s: got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_level(input string name, input async_fifo_pkg::level_t got,
                              input async_fifo_pkg::level_t exp);
      check_count++;
      if (got !== exp) begin
         err_count++;
         $display("ERROR %0t %s: got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      check_count++;
      if (got !== exp) begin
         err_count++;
         $display("ERROR %0t %s: got %b expected %b", $time, name, got, exp);
      end
   endtask

   // aw and w offered together, bready held until the response
   task automatic axil_write(input async_fifo_pkg::axil_addr_t addr,
                             input async_fifo_pkg::word_t data,
                             output async_fifo_pkg::resp_t resp);
      @(negedge rclk);
      axil_req.awvalid = 1'b1;
      axil_req.awaddr  = addr;
      axil_req.wvalid  = 1'b1;
      axil_req.wdata   = data;
      axil_req.wstrb   = '1;
      axil_req.bready  = 1'b1;
      while (!axil_rsp.awready) @(negedge rclk);  // handshake on next posedge
      check_bit("wready", axil_rsp.wready, 1'b1);  // pulses with awready
      @(negedge rclk);
      axil_req.awvalid = 1'b0;
      axil_req.wvalid  = 1'b0;
      while (!axil_rsp.bvalid) @(negedge rclk);
      resp = axil_rsp.bresp;
      @(negedge rclk);
      axil_req.bready = 1'b0;
   endtask

   task automatic axil_read(input async_fifo_pkg::axil_addr_t addr,
                            output async_fifo_pkg::word_t data,
                            output async_fifo_pkg::resp_t resp);
      @(negedge rclk);
      axil_req.arvalid = 1'b1;
      axil_req.araddr  = addr;
      axil_req.rready  = 1'b1;
      while (!axil_rsp.arready) @(negedge rclk);
      @(negedge rclk);
      axil_req.arvalid = 1'b0;
      while (!axil_rsp.rvalid) @(negedge rclk);
      data = axil_rsp.rdata;  // stable while rvalid
      resp = axil_rsp.rresp;
      @(negedge rclk);
      axil_req.rready = 1'b0;
   endtask

   task automatic push_word(input async_fifo_pkg::word_t data);
      @(negedge wclk);
      in_valid = 1'b1;
      in_data  = data;
      while (!in_ready) @(negedge wclk);  // taken on next wclk posedge
      sb.push_back(data);
      @(negedge wclk);
      in_valid = 1'b0;
   endtask

   // keep in_valid high until in_ready has been low for a long while
   task automatic fill_until_full(output int accepted);
      int idle;
      accepted = 0;
      idle     = 0;
      @(negedge wclk);
      in_valid = 1'b1;
      in_data  = $urandom;
      while (idle < 40) begin
         if (in_ready) begin
            sb.push_back(in_data);
            accepted++;
            idle = 0;
            @(negedge wclk);
            in_data = $urandom;  // next word
         end else begin
            idle++;
            @(negedge wclk);
         end
      end
      in_valid = 1'b0;
   endtask

   function automatic async_fifo_pkg::status_t to_status(input async_fifo_pkg::word_t w);
      return async_fifo_pkg::status_t'(w[$bits(async_fifo_pkg::status_t)-1:0]);
   endfunction

   // level reaches rclk after the pointer crossing, so poll
   task automatic poll_level(input int exp);
      async_fifo_pkg::word_t   data;
      async_fifo_pkg::resp_t   resp;
      async_fifo_pkg::status_t st;
      int                      tries;
      tries = 0;
      do begin
         axil_read(async_fifo_pkg::REG_STATUS, data, resp);
         st = to_status(data);
         tries++;
      end while (st.level != exp && tries < 40);
      if (st.level != exp) begin
         $display("level never settled at %0d, last seen %0d", exp, st.level);
      end
      check_level("status.level", st.level, async_fifo_pkg::level_t'(exp));
      check_bit("status.empty", st.empty, exp == 0);
   endtask

   task automatic drain_words(input int n);
      async_fifo_pkg::word_t data;
      async_fifo_pkg::resp_t resp;
      for (int i = 0; i < n; i++) begin
         axil_read(async_fifo_pkg::REG_DATA, data, resp);
         check_resp("rresp", resp, async_fifo_pkg::RESP_OKAY);
         check_word("data", data, (sb.size() > 0) ? sb.pop_front() : 'x);
      end
   endtask

   task automatic wait_in_ready(input int max_cycles);
      int n;
      n = 0;
      while (!in_ready && n < max_cycles) begin
         @(negedge wclk);
         n++;
      end
      check_bit("in_ready", in_ready, 1'b1);
   endtask

   task automatic finish_test(input string name, input int errs_before);
      test_count++;
      $display("%-10s done at %0t, %0d errors", name, $time, err_count - errs_before);
   endtask

   task automatic test_reset();
      async_fifo_pkg::word_t   data;
      async_fifo_pkg::resp_t   resp;
      async_fifo_pkg::status_t st;
      int                      errs;
      errs = err_count;
      axil_read(async_fifo_pkg::REG_STATUS, data, resp);
      st = to_status(data);
      check_resp("rresp", resp, async_fifo_pkg::RESP_OKAY);
      check_level("status.level", st.level, '0);
      check_bit("status.empty", st.empty, 1'b1);
      check_bit("status.underflow", st.underflow, 1'b0);
      axil_read(async_fifo_pkg::REG_CTRL, data, resp);
      check_word("ctrl", data, '0);
      check_bit("irq", irq, 1'b0);
      wait_in_ready(20);  // wclk reset sync takes a few edges
      finish_test("reset", errs);
   endtask

   task automatic test_ordering();
      int errs;
      errs = err_count;
      for (int i = 0; i < 10; i++) begin
         push_word($urandom);
      end
      poll_level(10);
      drain_words(10);
      poll_level(0);
      finish_test("ordering", errs);
   endtask

   task automatic test_capacity();
      int errs;
      int accepted;
      errs = err_count;
      fill_until_full(accepted);
      check_level("accepted", async_fifo_pkg::level_t'(accepted),
                  async_fifo_pkg::level_t'(CAPACITY));
      poll_level(CAPACITY);
      drain_words(accepted);
      poll_level(0);
      wait_in_ready(40);  // freed space crosses back late
      finish_test("capacity", errs);
   endtask

   task automatic test_underflow();
      async_fifo_pkg::word_t   data;
      async_fifo_pkg::resp_t   resp;
      async_fifo_pkg::status_t clr;
      async_fifo_pkg::status_t st;
      int                      errs;
      errs = err_count;
      axil_read(async_fifo_pkg::REG_DATA, data, resp);
      check_word("data", data, '0);
      check_resp("rresp", resp, async_fifo_pkg::RESP_SLVERR);
      axil_read(async_fifo_pkg::REG_STATUS, data, resp);
      st = to_status(data);
      check_bit("status.underflow", st.underflow, 1'b1);
      clr = '{underflow: 1'b1, empty: 1'b0, level: '0};  // w1c
      axil_write(async_fifo_pkg::REG_STATUS, async_fifo_pkg::word_t'(clr), resp);
      check_resp("bresp", resp, async_fifo_pkg::RESP_OKAY);
      axil_read(async_fifo_pkg::REG_STATUS, data, resp);
      st = to_status(data);
      check_bit("status.underflow", st.underflow, 1'b0);
      finish_test("underflow", errs);
   endtask

   task automatic test_irq();
      async_fifo_pkg::ctrl_t ctrl;
      async_fifo_pkg::resp_t resp;
      int                    errs;
      errs = err_count;
      ctrl = '{irq_en: 1'b1, threshold: 6'd5};
      axil_write(async_fifo_pkg::REG_CTRL, async_fifo_pkg::word_t'(ctrl), resp);
      check_resp("bresp", resp, async_fifo_pkg::RESP_OKAY);
      for (int i = 0; i < 4; i++) begin
         push_word($urandom);
      end
      poll_level(4);
      check_bit("irq", irq, 1'b0);  // one below threshold
      push_word($urandom);
      poll_level(5);
      check_bit("irq", irq, 1'b1);
      drain_words(1);
      repeat (2) @(negedge rclk);  // irq registered after level
      check_bit("irq", irq, 1'b0);
      ctrl = '{irq_en: 1'b0, threshold: 6'd0};  // would fire if enabled
      axil_write(async_fifo_pkg::REG_CTRL, async_fifo_pkg::word_t'(ctrl), resp);
      repeat (2) @(negedge rclk);
      check_bit("irq", irq, 1'b0);
      for (int i = 0; i < 3; i++) begin
         push_word($urandom);
      end
      poll_level(7);
      check_bit("irq", irq, 1'b0);
      drain_words(7);
      poll_level(0);
      finish_test("irq", errs);
   endtask

   task automatic test_decode();
      async_fifo_pkg::ctrl_t ctrl;
      async_fifo_pkg::word_t data;
      async_fifo_pkg::resp_t resp;
      int                    errs;
      errs = err_count;
      ctrl = '{irq_en: 1'b1, threshold: 6'd9};
      axil_write(async_fifo_pkg::REG_CTRL, async_fifo_pkg::word_t'(ctrl), resp);
      check_resp("bresp", resp, async_fifo_pkg::RESP_OKAY);
      axil_read(async_fifo_pkg::REG_CTRL, data, resp);
      check_word("ctrl", data, async_fifo_pkg::word_t'(ctrl));
      axil_write(8'hC, 32'hdead_beef, resp);  // unmapped
      check_resp("bresp", resp, async_fifo_pkg::RESP_SLVERR);
      axil_read(8'hC, data, resp);
      check_resp("rresp", resp, async_fifo_pkg::RESP_SLVERR);
      check_word("rdata", data, '0);
      axil_write(async_fifo_pkg::REG_DATA, 32'h1234_5678, resp);
      check_resp("bresp", resp, async_fifo_pkg::RESP_OKAY);
      poll_level(0);  // data write pushes nothing
      axil_read(async_fifo_pkg::REG_CTRL, data, resp);
      check_word("ctrl", data, async_fifo_pkg::word_t'(ctrl));
      axil_write(async_fifo_pkg::REG_CTRL, '0, resp);
      finish_test("decode", errs);
   endtask

   initial begin : watchdog
      #(WATCHDOG_CYCLES * RCLK_PERIOD);
      $display("timeout, run still busy after %0d rclk cycles", WATCHDOG_CYCLES);
      $display("Test failed");
      $finish;
   end

   initial begin
      void'($urandom(68));
      rclk        = 1'b0;
      wclk        = 1'b0;
      rst_n       = 1'b0;
      in_valid    = 1'b0;
      in_data     = '0;
      axil_req    = '0;
      err_count   = 0;
      check_count = 0;
      test_count  = 0;
      repeat (8) @(posedge rclk);
      @(negedge rclk);
      rst_n = 1'b1;
      test_reset();
      test_ordering();
      test_capacity();
      test_underflow();
      test_irq();
      test_decode();
      $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
      if (err_count == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: filelist.f
async_fifo_pkg.sv
dual_clock_ram.sv
gray_sync.sv
fifo_write_ctrl.sv
fifo_read_ctrl.sv
fifo_csr_axil.sv
async_fifo_top.sv
tb_async_fifo.sv
